//--- project.f
+incdir+.
i2cPkg.sv
i2cInterfaces.sv
i2cRegs.sv
i2cSequencer.sv
i2cByteEngine.sv
i2cMaster.sv
i2cSlaveModel.sv
tb_i2cMaster.sv

//--- tb_i2cMaster.sv
`timescale 1ns/1ps
`include "i2c_settings.svh"

module tb_i2cMaster;
    import i2cPkg::*;

    localparam time clkPeriod      = 100;
    localparam int  resetCycles    = 16;
    localparam int  randomPairs    = 12;
    localparam int  transactions   = 4 + 2 * randomPairs;
    localparam time watchdogLimit  =
        2 * (transactions * 45 * `I2C_PHASES * clkPeriod + resetCycles * clkPeriod);
    localparam devAddr_t slaveAddr = 7'h4B;

    logic      FSM_Clk;
    logic      reset;
    logic      hostWrite;
    hostAddr_t hostAddr;
    i2cByte_t  hostWrData;
    hostAddr_t hostRdAddr;
    i2cByte_t  hostRdData;
    logic      scl;
    logic      sdaPullLow;
    logic      sdaIn;

    int       errorCount  = 0;
    int       testsRun    = 0;
    int       testsFailed = 0;
    i2cByte_t expMem [0:15];

    i2cMaster DUT (
        .FSM_Clk    (FSM_Clk),
        .reset      (reset),
        .hostWrite  (hostWrite),
        .hostAddr   (hostAddr),
        .hostWrData (hostWrData),
        .hostRdAddr (hostRdAddr),
        .hostRdData (hostRdData),
        .scl        (scl),
        .sdaPullLow (sdaPullLow),
        .sdaIn      (sdaIn)
    );

    i2cSlaveModel slave (
        .scl        (scl),
        .sdaPullLow (sdaPullLow),
        .sdaIn      (sdaIn)
    );

    initial begin
        FSM_Clk = 1'b0;
        forever #(clkPeriod / 2) FSM_Clk = ~FSM_Clk;
    end

    task automatic checkValue(input string sigName, input i2cByte_t expected,
                              input i2cByte_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t ns: %s expected 8'h%02h, got 8'h%02h",
                     $time, sigName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("Test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("Test %0d %s: %0d errors", testsRun, name, errorCount - errorsBefore);
        end
    endtask

    task automatic writeReg(input hostAddr_t addr, input i2cByte_t data);
        @(negedge FSM_Clk);
        hostWrite  = 1'b1;
        hostAddr   = addr;
        hostWrData = data;
        @(negedge FSM_Clk);
        hostWrite = 1'b0;
    endtask

    // Sample the combinational readback one falling edge later
    task automatic readReg(input hostAddr_t addr, output i2cByte_t data);
        @(negedge FSM_Clk);
        hostRdAddr = addr;
        @(negedge FSM_Clk);
        data = hostRdData;
    endtask

    task automatic startTransfer(input logic isRead);
        writeReg(`REG_CTRL, {6'b0, isRead, 1'b1});
    endtask

    task automatic waitIdle();
        i2cByte_t status;
        status = 8'h01;
        while (status[0]) begin
            readReg(`REG_STATUS, status);
        end
    endtask

    task automatic runWrite(input devAddr_t dev, input i2cByte_t sub, input i2cByte_t data);
        writeReg(`REG_DEV, i2cByte_t'(dev));
        writeReg(`REG_SUB, sub);
        writeReg(`REG_WDATA, data);
        startTransfer(1'b0);
        waitIdle();
    endtask

    task automatic runRead(input devAddr_t dev, input i2cByte_t sub);
        writeReg(`REG_DEV, i2cByte_t'(dev));
        writeReg(`REG_SUB, sub);
        startTransfer(1'b1);
        waitIdle();
    endtask

    initial begin
        #(watchdogLimit);
        $display("Watchdog expired at %0t ns, a transaction never finished", $time);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int       mark;
        int       writesBefore;
        int       seedValue;
        i2cByte_t value;
        i2cByte_t sub;
        i2cByte_t data;

        seedValue  = $urandom(32'he68a_4cbf);
        reset      = 1'b1;
        hostWrite  = 1'b0;
        hostAddr   = '0;
        hostWrData = '0;
        hostRdAddr = '0;
        for (int i = 0; i < 16; i++) begin
            expMem[i] = 8'(i) ^ 8'hA5;
        end
        repeat (resetCycles) @(posedge FSM_Clk);
        @(negedge FSM_Clk);
        reset = 1'b0;

        mark = errorCount;
        checkValue("scl", 8'h01, i2cByte_t'(scl));
        checkValue("sdaPullLow", 8'h00, i2cByte_t'(sdaPullLow));
        readReg(`REG_STATUS, value);
        checkValue("STATUS", 8'h00, value);
        writeReg(`REG_DEV, i2cByte_t'(slaveAddr));
        writeReg(`REG_SUB, 8'h3C);
        writeReg(`REG_WDATA, 8'h96);
        readReg(`REG_DEV, value);
        checkValue("DEV", i2cByte_t'(slaveAddr), value);
        readReg(`REG_SUB, value);
        checkValue("SUB", 8'h3C, value);
        readReg(`REG_WDATA, value);
        checkValue("WDATA", 8'h96, value);
        reportTest("reset state", mark);

        mark = errorCount;
        runWrite(slaveAddr, 8'h03, 8'h5C);
        expMem[3] = 8'h5C;
        readReg(`REG_STATUS, value);
        checkValue("STATUS", 8'h00, value);
        checkValue("slave.mem[3]", expMem[3], slave.mem[3]);
        reportTest("register write", mark);

        mark = errorCount;
        runRead(slaveAddr, 8'h07);
        readReg(`REG_STATUS, value);
        checkValue("STATUS", 8'h00, value);
        readReg(`REG_RDATA, value);
        checkValue("RDATA", expMem[7], value);
        reportTest("register read", mark);

        mark         = errorCount;
        writesBefore = slave.writeCount;
        runWrite(7'h22, 8'h04, 8'h11);
        readReg(`REG_STATUS, value);
        checkValue("STATUS", 8'h02, value);
        checkValue("slave write count", 8'(writesBefore), 8'(slave.writeCount));
        checkValue("slave.mem[4]", expMem[4], slave.mem[4]);
        checkValue("scl", 8'h01, i2cByte_t'(scl));
        checkValue("sdaPullLow", 8'h00, i2cByte_t'(sdaPullLow));
        reportTest("wrong device", mark);

        mark         = errorCount;
        writesBefore = slave.writeCount;
        writeReg(`REG_DEV, i2cByte_t'(slaveAddr));
        writeReg(`REG_SUB, 8'h09);
        writeReg(`REG_WDATA, 8'h3E);
        startTransfer(1'b0);
        readReg(`REG_STATUS, value);
        assert (value[0]) else begin
            $display("At %0t ns the master was not busy right after go", $time);
            errorCount++;
        end
        // Second go asks for a read in the middle of the write
        startTransfer(1'b1);
        waitIdle();
        expMem[9] = 8'h3E;
        repeat (20) @(negedge FSM_Clk);
        readReg(`REG_STATUS, value);
        checkValue("STATUS", 8'h00, value);
        checkValue("slave write count", 8'(writesBefore + 1), 8'(slave.writeCount));
        checkValue("slave.mem[9]", expMem[9], slave.mem[9]);
        reportTest("go while busy", mark);

        mark = errorCount;
        for (int n = 0; n < randomPairs; n++) begin
            sub  = 8'($urandom_range(15, 0));
            data = 8'($urandom);
            runWrite(slaveAddr, sub, data);
            expMem[sub[3:0]] = data;
            readReg(`REG_STATUS, value);
            checkValue("STATUS", 8'h00, value);
            runRead(slaveAddr, sub);
            readReg(`REG_STATUS, value);
            checkValue("STATUS", 8'h00, value);
            readReg(`REG_RDATA, value);
            checkValue("RDATA", expMem[sub[3:0]], value);
        end
        reportTest("random traffic", mark);

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- i2cSlaveModel.sv
`timescale 1ns/1ps

module i2cSlaveModel (
    input  logic scl,
    input  logic sdaPullLow,
    output logic sdaIn
);

    localparam logic [6:0] ownAddr = 7'h4B;

    typedef enum {
        modeIdle,
        modeAddr,
        modeSub,
        modeWrite,
        modeRead,
        modeIgnore
    } slaveMode_t;

    logic [7:0] mem [0:15];
    slaveMode_t mode       = modeIdle;
    slaveMode_t nextMode   = modeIgnore;
    logic       pullLow    = 1'b0;
    logic       skipEdge   = 1'b0;
    logic       prevScl    = 1'bx;
    logic       prevSda    = 1'bx;
    logic [3:0] bitIdx     = 4'd0;
    logic [7:0] shiftIn    = 8'h00;
    logic [7:0] txByte     = 8'h00;
    logic [3:0] ptr        = 4'd0;
    int         writeCount = 0;
    wire        sda;

    // Wired-AND of both open-drain drivers
    assign sda   = ~(sdaPullLow | pullLow);
    assign sdaIn = sda;

    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i] = 8'(i) ^ 8'hA5;
        end
    end

    always @(scl or sda) begin
        if (prevScl === 1'b1 && scl === 1'b1 && prevSda === 1'b1 && sda === 1'b0) begin
            // Start or repeated start
            mode     = modeAddr;
            bitIdx   = 4'd0;
            skipEdge = 1'b1;
            pullLow  = 1'b0;
        end else if (prevScl === 1'b1 && scl === 1'b1 && prevSda === 1'b0 && sda === 1'b1) begin
            mode    = modeIdle;
            pullLow = 1'b0;
        end else if (prevScl === 1'b0 && scl === 1'b1) begin
            if (bitIdx < 4'd8 && (mode == modeAddr || mode == modeSub || mode == modeWrite)) begin
                shiftIn = {shiftIn[6:0], sda};
            end
        end else if (prevScl === 1'b1 && scl === 1'b0) begin
            if (skipEdge) begin
                // Falling edge that closes the start condition
                skipEdge = 1'b0;
            end else if (mode != modeIdle) begin
                if (bitIdx == 4'd8) begin
                    // End of the acknowledge slot
                    pullLow = 1'b0;
                    bitIdx  = 4'd0;
                    mode    = nextMode;
                    if (mode == modeRead) begin
                        txByte  = mem[ptr];
                        pullLow = ~txByte[7];
                    end
                end else begin
                    bitIdx = bitIdx + 4'd1;
                    if (bitIdx == 4'd8) begin
                        case (mode)
                            modeAddr: begin
                                if (shiftIn[7:1] == ownAddr) begin
                                    pullLow  = 1'b1;
                                    nextMode = shiftIn[0] ? modeRead : modeSub;
                                end else begin
                                    nextMode = modeIgnore;
                                end
                            end
                            modeSub: begin
                                ptr      = shiftIn[3:0];
                                pullLow  = 1'b1;
                                nextMode = modeWrite;
                            end
                            modeWrite: begin
                                mem[ptr]   = shiftIn;
                                writeCount = writeCount + 1;
                                pullLow    = 1'b1;
                                nextMode   = modeIgnore;
                            end
                            modeRead: begin
                                // Master answers in this slot
                                pullLow  = 1'b0;
                                nextMode = modeIgnore;
                            end
                            default: nextMode = modeIgnore;
                        endcase
                    end else if (mode == modeRead) begin
                        pullLow = ~txByte[7 - bitIdx];
                    end
                end
            end
        end
        prevScl = scl;
        prevSda = sda;
    end

endmodule

//--- i2cMaster.sv
`timescale 1ns/1ps

module i2cMaster (
    input  logic              FSM_Clk,
    input  logic              reset,
    input  logic              hostWrite,
    input  i2cPkg::hostAddr_t hostAddr,
    input  i2cPkg::i2cByte_t  hostWrData,
    input  i2cPkg::hostAddr_t hostRdAddr,
    output i2cPkg::i2cByte_t  hostRdData,
    output logic              scl,
    output logic              sdaPullLow,
    input  logic              sdaIn
);

    i2cCmdIf  cmdBus ();
    i2cByteIf byteBus ();

    // Host register block
    i2cRegs regsInst (
        .FSM_Clk    (FSM_Clk),
        .reset      (reset),
        .hostWrite  (hostWrite),
        .hostAddr   (hostAddr),
        .hostWrData (hostWrData),
        .hostRdAddr (hostRdAddr),
        .hostRdData (hostRdData),
        .cmd        (cmdBus)
    );

    i2cSequencer seqInst (
        .FSM_Clk (FSM_Clk),
        .reset   (reset),
        .cmd     (cmdBus),
        .bus     (byteBus)
    );

    // Drives the pins
    i2cByteEngine engineInst (
        .FSM_Clk    (FSM_Clk),
        .reset      (reset),
        .bus        (byteBus),
        .scl        (scl),
        .sdaPullLow (sdaPullLow),
        .sdaIn      (sdaIn)
    );

endmodule

//--- i2cByteEngine.sv
`timescale 1ns/1ps
`include "i2c_settings.svh"

module i2cByteEngine (
    input  logic     FSM_Clk,
    input  logic     reset,
    i2cByteIf.engine bus,
    output logic     scl,
    output logic     sdaPullLow,
    input  logic     sdaIn
);
    import i2cPkg::*;

    localparam int phaseW = $clog2(`I2C_PHASES);
    localparam int bitW   = $clog2(`I2C_BYTE_W);
    localparam logic [phaseW-1:0] lastPhase   = phaseW'(`I2C_PHASES - 1);
    localparam logic [phaseW-1:0] samplePhase = phaseW'(2);
    localparam logic [bitW-1:0]   lastBit     = bitW'(`I2C_BYTE_W - 1);

    // Bit n of each condition waveform is the level in phase n
    localparam logic [`I2C_PHASES-1:0] startScl    = 4'b0111;
    localparam logic [`I2C_PHASES-1:0] startPull   = 4'b1110;
    localparam logic [`I2C_PHASES-1:0] restartScl  = 4'b0110;
    localparam logic [`I2C_PHASES-1:0] restartPull = 4'b1100;
    localparam logic [`I2C_PHASES-1:0] stopScl     = 4'b1110;
    localparam logic [`I2C_PHASES-1:0] stopPull    = 4'b0011;

    engState_t              state;
    byteCmd_t               curCmd;
    logic [phaseW-1:0]      phase;
    logic [bitW-1:0]        bitCnt;
    i2cByte_t               shiftReg;
    logic                   ackReg;
    logic                   readyReg;
    logic                   doneReg;
    logic                   accept;
    logic [`I2C_PHASES-1:0] condScl;
    logic [`I2C_PHASES-1:0] condPull;

    assign accept = (state == engIdle) && bus.req;

    always_comb begin
        case (curCmd)
            cmdStart: begin
                condScl  = startScl;
                condPull = startPull;
            end
            cmdRestart: begin
                condScl  = restartScl;
                condPull = restartPull;
            end
            default: begin
                condScl  = stopScl;
                condPull = stopPull;
            end
        endcase
    end

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            state      <= engIdle;
            phase      <= '0;
            bitCnt     <= '0;
            readyReg   <= 1'b1;
            doneReg    <= 1'b0;
            scl        <= 1'b1;
            sdaPullLow <= 1'b0;
        end else begin
            doneReg <= 1'b0;
            phase   <= (phase == lastPhase) ? '0 : phase + 1'b1;
            case (state)
                engIdle: begin
                    phase  <= '0;
                    bitCnt <= '0;
                    if (bus.req) begin
                        readyReg <= 1'b0;
                        if ((bus.cmd == cmdWriteByte) || (bus.cmd == cmdReadByte)) begin
                            state <= engShift;
                        end else begin
                            state <= engCondition;
                        end
                    end
                end
                engCondition: begin
                    scl        <= condScl[phase];
                    sdaPullLow <= condPull[phase];
                    if (phase == lastPhase) begin
                        state    <= engIdle;
                        readyReg <= 1'b1;
                        doneReg  <= 1'b1;
                    end
                end
                engShift: begin
                    case (phase)
                        0: begin
                            scl        <= 1'b0;
                            sdaPullLow <= ~shiftReg[`I2C_BYTE_W-1];
                        end
                        1, 2:    scl <= 1'b1;
                        default: scl <= 1'b0;
                    endcase
                    if (phase == lastPhase) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == lastBit) begin
                            state <= engAck;
                        end
                    end
                end
                engAck: begin
                    // Releasing SDA here also gives the NACK after a read
                    case (phase)
                        0: begin
                            scl        <= 1'b0;
                            sdaPullLow <= 1'b0;
                        end
                        1, 2:    scl <= 1'b1;
                        default: scl <= 1'b0;
                    endcase
                    if (phase == lastPhase) begin
                        state    <= engIdle;
                        readyReg <= 1'b1;
                        doneReg  <= 1'b1;
                    end
                end
                default: state <= engIdle;
            endcase
        end
    end

    always_ff @(posedge FSM_Clk) begin
        if (accept) begin
            curCmd   <= bus.cmd;
            // All ones keeps SDA released while a read shifts in
            shiftReg <= (bus.cmd == cmdReadByte) ? '1 : bus.txByte;
        end else if (phase == samplePhase) begin
            if (state == engShift) begin
                shiftReg <= {shiftReg[`I2C_BYTE_W-2:0], sdaIn};
            end
            if (state == engAck) begin
                ackReg <= sdaIn;
            end
        end
    end

    assign bus.ready   = readyReg;
    assign bus.symDone = doneReg;
    assign bus.ack     = ackReg;
    assign bus.rxByte  = shiftReg;

endmodule

//--- i2cSequencer.sv
`timescale 1ns/1ps

module i2cSequencer (
    input logic   FSM_Clk,
    input logic   reset,
    i2cCmdIf.seq  cmd,
    i2cByteIf.seq bus
);
    import i2cPkg::*;

    seqState_t state;
    seqState_t nextState;
    byteCmd_t  cmdSel;
    i2cByte_t  txSel;
    i2cByte_t  rdReg;
    logic      byteSent;
    logic      pending;
    logic      reqNow;
    logic      busyReg;
    logic      doneReg;
    logic      nackReg;

    // Bytes whose acknowledge slot decides the path
    assign byteSent = (state == seqDevWrite) || (state == seqSubAddr) ||
                      (state == seqWriteData) || (state == seqDevRead);

    always_comb begin
        case (state)
            seqStart:     nextState = seqDevWrite;
            seqDevWrite:  nextState = seqSubAddr;
            seqSubAddr:   nextState = cmd.isRead ? seqRestart : seqWriteData;
            seqWriteData: nextState = seqStop;
            seqRestart:   nextState = seqDevRead;
            seqDevRead:   nextState = seqReadData;
            seqReadData:  nextState = seqStop;
            default:      nextState = seqIdle;
        endcase
        // Missing acknowledge closes the bus
        if (byteSent && bus.ack) begin
            nextState = seqStop;
        end
    end

    // One engine command per state
    always_comb begin
        txSel  = cmd.subAddr;
        cmdSel = cmdWriteByte;
        case (state)
            seqStart:     cmdSel = cmdStart;
            seqDevWrite:  txSel  = {cmd.devAddr, 1'b0};
            seqWriteData: txSel  = cmd.wrData;
            seqRestart:   cmdSel = cmdRestart;
            seqDevRead:   txSel  = {cmd.devAddr, 1'b1};
            seqReadData:  cmdSel = cmdReadByte;
            seqStop:      cmdSel = cmdStop;
            default:      ;
        endcase
    end

    assign reqNow = pending && bus.ready;

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            state   <= seqIdle;
            pending <= 1'b0;
            busyReg <= 1'b0;
            doneReg <= 1'b0;
            nackReg <= 1'b0;
        end else begin
            doneReg <= 1'b0;
            if (reqNow) begin
                pending <= 1'b0;
            end
            if (state == seqIdle) begin
                if (cmd.go) begin
                    state   <= seqStart;
                    pending <= 1'b1;
                    busyReg <= 1'b1;
                    nackReg <= 1'b0;
                end
            end else if (bus.symDone) begin
                state   <= nextState;
                pending <= (nextState != seqIdle);
                if (byteSent && bus.ack) begin
                    nackReg <= 1'b1;
                end
                if (nextState == seqIdle) begin
                    busyReg <= 1'b0;
                    doneReg <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge FSM_Clk) begin
        if (bus.symDone && (state == seqReadData)) begin
            rdReg <= bus.rxByte;
        end
    end

    assign bus.cmd    = cmdSel;
    assign bus.txByte = txSel;
    assign bus.req    = reqNow;
    assign cmd.busy   = busyReg;
    assign cmd.done   = doneReg;
    assign cmd.nack   = nackReg;
    assign cmd.rdData = rdReg;

endmodule

//--- i2cRegs.sv
`timescale 1ns/1ps
`include "i2c_settings.svh"

module i2cRegs (
    input  logic              FSM_Clk,
    input  logic              reset,
    input  logic              hostWrite,
    input  i2cPkg::hostAddr_t hostAddr,
    input  i2cPkg::i2cByte_t  hostWrData,
    input  i2cPkg::hostAddr_t hostRdAddr,
    output i2cPkg::i2cByte_t  hostRdData,
    i2cCmdIf.regs             cmd
);
    import i2cPkg::*;

    devAddr_t devReg;
    i2cByte_t subReg;
    i2cByte_t wrReg;
    i2cByte_t rdReg;
    logic     readReg;
    logic     goReg;
    logic     nackReg;
    logic     busyView;
    logic     launch;

    // Host view of busy includes the go and done cycles
    assign busyView = goReg | cmd.busy | cmd.done;
    assign launch   = hostWrite && (hostAddr == `REG_CTRL) && hostWrData[0] && !busyView;

    always_ff @(posedge FSM_Clk) begin
        if (hostWrite) begin
            case (hostAddr)
                `REG_DEV:   devReg <= hostWrData[`I2C_DEV_W-1:0];
                `REG_SUB:   subReg <= hostWrData;
                `REG_WDATA: wrReg  <= hostWrData;
                default:    ;
            endcase
        end
        if (launch) begin
            readReg <= hostWrData[1];
        end
        if (cmd.done) begin
            rdReg <= cmd.rdData;
        end
    end

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            goReg   <= 1'b0;
            nackReg <= 1'b0;
        end else begin
            goReg <= launch;
            if (cmd.done) begin
                nackReg <= cmd.nack;
            end
        end
    end

    assign cmd.go      = goReg;
    assign cmd.isRead  = readReg;
    assign cmd.devAddr = devReg;
    assign cmd.subAddr = subReg;
    assign cmd.wrData  = wrReg;

    // Host readback
    always_comb begin
        case (hostRdAddr)
            `REG_DEV:    hostRdData = {{(`I2C_BYTE_W-`I2C_DEV_W){1'b0}}, devReg};
            `REG_SUB:    hostRdData = subReg;
            `REG_WDATA:  hostRdData = wrReg;
            `REG_STATUS: hostRdData = {{(`I2C_BYTE_W-2){1'b0}}, nackReg, busyView};
            `REG_RDATA:  hostRdData = rdReg;
            default:     hostRdData = '0;
        endcase
    end

endmodule

//--- i2cInterfaces.sv
`timescale 1ns/1ps

// Transaction request and result between register block and sequencer
interface i2cCmdIf;
    import i2cPkg::*;

    logic     go;
    logic     isRead;
    devAddr_t devAddr;
    i2cByte_t subAddr;
    i2cByte_t wrData;
    logic     busy;
    logic     done;
    i2cByte_t rdData;
    logic     nack;

    modport regs (
        output go, isRead, devAddr, subAddr, wrData,
        input  busy, done, rdData, nack
    );

    modport seq (
        input  go, isRead, devAddr, subAddr, wrData,
        output busy, done, rdData, nack
    );
endinterface

// One bus symbol per request
interface i2cByteIf;
    import i2cPkg::*;

    byteCmd_t cmd;
    i2cByte_t txByte;
    logic     req;
    logic     ready;
    logic     ack;
    i2cByte_t rxByte;
    logic     symDone;

    modport seq (
        output cmd, txByte, req,
        input  ready, ack, rxByte, symDone
    );

    modport engine (
        input  cmd, txByte, req,
        output ready, ack, rxByte, symDone
    );
endinterface

//--- i2cPkg.sv
`include "i2c_settings.svh"

package i2cPkg;

    typedef logic [`I2C_BYTE_W-1:0]      i2cByte_t;
    typedef logic [`I2C_DEV_W-1:0]       devAddr_t;
    typedef logic [`I2C_HOST_ADDR_W-1:0] hostAddr_t;

    // Symbols the byte engine puts on the bus
    typedef enum logic [2:0] {
        cmdStart,
        cmdRestart,
        cmdStop,
        cmdWriteByte,
        cmdReadByte
    } byteCmd_t;

    typedef enum logic [3:0] {
        seqIdle,
        seqStart,
        seqDevWrite,
        seqSubAddr,
        seqWriteData,
        seqRestart,
        seqDevRead,
        seqReadData,
        seqStop
    } seqState_t;

    typedef enum logic [1:0] {
        engIdle,
        engCondition,
        engShift,
        engAck
    } engState_t;

endpackage

//--- i2c_settings.svh
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// Bus field widths
`define I2C_BYTE_W      8
`define I2C_DEV_W       7

// Clock phases in one SCL symbol
`define I2C_PHASES      4

// Host register map
`define I2C_HOST_ADDR_W 3
`define REG_CTRL        3'd0
`define REG_DEV         3'd1
`define REG_SUB         3'd2
`define REG_WDATA       3'd3
`define REG_STATUS      3'd4
`define REG_RDATA       3'd5

`endif
